// ==== Bender.yml ====
package:
  name: thermal_cam

sources:
  - files:
      - verilog/thermal_cam_pkg.sv
      - verilog/i2c_cmd_if.sv
      - verilog/mem_req_if.sv
      - verilog/i2c_master.sv
      - verilog/cam_sequencer.sv
      - verilog/frame_buffer.sv
      - verilog/spi_target.sv
      - verilog/thermal_cam_top.sv
  - target: test
    files:
      - verification/cam_sensor_model.sv
      - verification/tb_thermal_cam.sv

// ==== thermal_cam_top.f ====
verilog/thermal_cam_pkg.sv
verilog/i2c_cmd_if.sv
verilog/mem_req_if.sv
verilog/i2c_master.sv
verilog/cam_sequencer.sv
verilog/frame_buffer.sv
verilog/spi_target.sv
verilog/thermal_cam_top.sv
verification/cam_sensor_model.sv
verification/tb_thermal_cam.sv

// ==== verification/cam_sensor_model.sv ====
// Behavioral I2C thermal sensor with a register write log and an EEPROM image
`timescale 1ns/100ps

module cam_sensor_model #(
    parameter int ROM_BYTES = 64
) (
    input  logic scl,
    input  logic sda,
    output logic sda_release,
    input  logic nack_addr,
    input  int   not_ready_reads
);
    import thermal_cam_pkg::*;

    localparam int COND_START = 1;
    localparam int COND_STOP  = 2;

    // Image is loaded by the testbench before the first read
    logic [7:0]  image [ROM_BYTES];
    logic [15:0] wr_addr [8];
    logic [15:0] wr_data [8];
    int          wr_count = 0;
    int          status_reads = 0;
    logic [15:0] pointer = 16'h0000;

    // One bit, with start or stop seen while SCL is high
    task automatic recv_bit(output logic v, output int cond);
        @(posedge scl);
        v = sda;
        cond = 0;
        while (scl === 1'b1 && cond == 0) begin
            @(scl or sda);
            if (scl === 1'b1 && sda !== v) cond = sda ? COND_STOP : COND_START;
        end
    endtask

    task automatic recv_byte(output logic [7:0] b, output int cond);
        logic v;
        b = '0;
        cond = 0;
        for (int i = 0; i < 8 && cond == 0; i++) begin
            recv_bit(v, cond);
            b = {b[6:0], v};
        end
    endtask

    task automatic send_ack();
        sda_release = 1'b0;
        @(posedge scl);
        @(negedge scl);
        sda_release = 1'b1;
    endtask

    // Host NACK ends the read
    task automatic send_byte(input logic [7:0] b, output logic acked);
        for (int i = 7; i >= 0; i--) begin
            sda_release = b[i];
            @(posedge scl);
            @(negedge scl);
        end
        sda_release = 1'b1;
        @(posedge scl);
        acked = !sda;
        @(negedge scl);
    endtask

    function automatic logic [7:0] read_byte(input int idx);
        logic [15:0] status;
        status = '0;
        // Data ready once the host has polled past the not-ready count
        status[STATUS_READY_BIT] = (status_reads > not_ready_reads);
        if (pointer == REG_STATUS) return (idx == 0) ? status[15:8] : status[7:0];
        return image[(int'(pointer - EEPROM_BASE) + idx) % ROM_BYTES];
    endfunction

    task automatic transfer();
        logic [7:0]  b;
        logic [15:0] word;
        logic        acked;
        logic        again;
        int          cond;
        int          n;
        again = 1'b1;
        while (again) begin
            recv_byte(b, cond);
            if (cond == 0 && b[7:1] == CAM_I2C_ADDR && !nack_addr) begin
                send_ack();
                n = 0;
                if (!b[0]) begin
                    // Two pointer bytes, then two data bytes
                    while (cond == 0) begin
                        recv_byte(b, cond);
                        if (cond == 0) begin
                            if (n < 2) pointer = {pointer[7:0], b};
                            else word = {word[7:0], b};
                            n++;
                            if (n == 4) begin
                                if (wr_count < 8) begin
                                    wr_addr[wr_count] = pointer;
                                    wr_data[wr_count] = word;
                                end
                                wr_count++;
                            end
                            send_ack();
                        end
                    end
                end else begin
                    if (pointer == REG_STATUS) status_reads++;
                    acked = 1'b1;
                    while (acked) begin
                        send_byte(read_byte(n), acked);
                        n++;
                    end
                end
            end
            again = (cond == COND_START);
        end
    endtask

    initial begin
        sda_release = 1'b1;
        forever begin
            @(negedge sda);
            if (scl === 1'b1) transfer();
        end
    end
endmodule

// ==== verification/tb_thermal_cam.sv ====
// Testbench for the thermal camera bridge with a sensor model and an SPI host
`timescale 1ns/100ps

module tb_thermal_cam;
    import thermal_cam_pkg::*;

    localparam int ROM_BYTES       = 64;
    localparam int CLK_DIV         = 2;
    localparam int POLL_WAIT       = 200;
    localparam int NOT_READY_READS = 2;
    localparam int SPI_HALF        = 8;
    localparam logic [31:0] SEED   = 32'hcb8d_5024;

    // Bytes on the bus for three writes, the EEPROM dump and the status polls
    localparam int I2C_BYTES = 3 * 5 + (4 + ROM_BYTES) + (NOT_READY_READS + 1) * 6;
    // Nine bits per byte plus start, restart and stop bit times
    localparam int I2C_BITS     = I2C_BYTES * 9 + 4 * (5 + NOT_READY_READS);
    localparam int FRAME_CYCLES = 2 * (I2C_BITS * 4 * CLK_DIV + NOT_READY_READS * POLL_WAIT)
                                  + 1000;
    localparam int SPI_CYCLES   = ((16 + ROM_BYTES * 8) + 3 * (16 + 32)) * 2 * SPI_HALF + 500;
    localparam int WATCHDOG_CYCLES = 2 * FRAME_CYCLES + SPI_CYCLES + 4 * POLL_WAIT + 2000;

    logic        clk = 1'b0;
    logic        reset;
    logic        scl;
    logic        sda_oe;
    logic        sda;
    logic        sck;
    logic        cs;
    logic        copi;
    logic        cipo;
    logic        frame_ready;
    logic        error;
    logic        sda_release;
    logic        nack_addr;
    int          not_ready;
    logic [31:0] lfsr;
    logic [7:0]  spi_rx [$];
    string       test_name;
    int          test_errors;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          total_errors = 0;

    // Open-drain SDA
    assign sda = !sda_oe && sda_release;

    thermal_cam_top #(
        .ROM_BYTES(ROM_BYTES),
        .CLK_DIV(CLK_DIV),
        .POLL_WAIT_CYCLES(POLL_WAIT)
    ) uut (
        .clk(clk),
        .reset(reset),
        .scl(scl),
        .sda_oe(sda_oe),
        .sda_in(sda),
        .sck(sck),
        .cs(cs),
        .copi(copi),
        .cipo(cipo),
        .frame_ready(frame_ready),
        .error(error)
    );

    cam_sensor_model #(
        .ROM_BYTES(ROM_BYTES)
    ) sensor (
        .scl(scl),
        .sda(sda),
        .sda_release(sda_release),
        .nack_addr(nack_addr),
        .not_ready_reads(not_ready)
    );

    always #5 clk = ~clk;

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic open_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic close_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: ok", test_name);
        end else begin
            $display("%s: %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic expect_value(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error in %s, %s: expected %0h actual %0h", test_name, what,
                     expected, actual);
            test_errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("%s: %s", test_name, msg);
            test_errors++;
        end
    endtask

    task automatic wait_for_outcome(output logic timed_out);
        int n;
        n = 0;
        while (frame_ready !== 1'b1 && error !== 1'b1 && n < FRAME_CYCLES) begin
            @(negedge clk);
            n++;
        end
        timed_out = (n >= FRAME_CYCLES);
    endtask

    // Mode 0 host samples CIPO just before the rising SCK edge
    task automatic shift_bit(input logic out_bit, output logic in_bit);
        copi = out_bit;
        repeat (SPI_HALF) @(negedge clk);
        in_bit = cipo;
        sck = 1'b1;
        repeat (SPI_HALF) @(negedge clk);
        sck = 1'b0;
    endtask

    task automatic read_buffer(input int start, input int count);
        logic [15:0] a;
        logic [7:0]  b;
        logic        v;
        a = 16'(start);
        spi_rx.delete();
        cs = 1'b0;
        for (int i = 15; i >= 0; i--) begin
            shift_bit(a[i], v);
        end
        for (int n = 0; n < count; n++) begin
            for (int i = 0; i < 8; i++) begin
                shift_bit(1'b0, v);
                b = {b[6:0], v};
            end
            spi_rx.push_back(b);
        end
        cs = 1'b1;
        repeat (SPI_HALF) @(negedge clk);
    endtask

    task automatic reset_outputs();
        open_test("reset_outputs");
        reset = 1'b1;
        repeat (10) @(negedge clk);
        expect_value("frame_ready", 0, frame_ready);
        expect_value("error", 0, error);
        expect_value("sda_oe", 0, sda_oe);
        expect_value("scl", 1, scl);
        reset = 1'b0;
        close_test();
    endtask

    task automatic status_polling();
        logic timed_out;
        open_test("status_polling");
        wait_for_outcome(timed_out);
        expect_true(!timed_out, "frame_ready did not rise before the timeout");
        expect_value("frame_ready", 1, frame_ready);
        expect_value("error", 0, error);
        expect_value("status reads", NOT_READY_READS + 1, sensor.status_reads);
        close_test();
    endtask

    task automatic config_writes();
        open_test("config_writes");
        expect_value("write count", 3, sensor.wr_count);
        expect_value("write 0 register", REG_CONTROL, sensor.wr_addr[0]);
        expect_value("write 0 value", CONTROL_VALUE, sensor.wr_data[0]);
        expect_value("write 1 register", REG_CONFIG, sensor.wr_addr[1]);
        expect_value("write 1 value", CONFIG_VALUE, sensor.wr_data[1]);
        expect_value("write 2 register", REG_STATUS, sensor.wr_addr[2]);
        expect_value("write 2 value", STATUS_CLEAR, sensor.wr_data[2]);
        close_test();
    endtask

    task automatic burst_readback();
        open_test("burst_readback");
        read_buffer(0, ROM_BYTES);
        for (int i = 0; i < ROM_BYTES; i++) begin
            expect_value($sformatf("address %0d", i), sensor.image[i], spi_rx[i]);
        end
        close_test();
    endtask

    task automatic random_readback();
        int start;
        open_test("random_readback");
        for (int k = 0; k < 3; k++) begin
            start = int'(lfsr_bits(6) % 60);
            read_buffer(start, 4);
            for (int j = 0; j < 4; j++) begin
                expect_value($sformatf("address %0d", start + j), sensor.image[start + j],
                             spi_rx[j]);
            end
        end
        close_test();
    endtask

    task automatic address_nack();
        logic timed_out;
        logic seen_ready;
        open_test("address_nack");
        nack_addr = 1'b1;
        sensor.wr_count = 0;
        reset = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        wait_for_outcome(timed_out);
        expect_true(!timed_out, "error did not rise after the address NACK");
        expect_value("error", 1, error);
        seen_ready = 1'b0;
        // Sequencer must stay stopped
        repeat (4 * POLL_WAIT) begin
            @(negedge clk);
            if (frame_ready) seen_ready = 1'b1;
        end
        expect_value("frame_ready", 0, seen_ready);
        expect_value("register writes", 0, sensor.wr_count);
        close_test();
    endtask

    initial begin
        reset = 1'b1;
        sck = 1'b0;
        cs = 1'b1;
        copi = 1'b0;
        nack_addr = 1'b0;
        not_ready = NOT_READY_READS;
        lfsr = SEED;
        for (int i = 0; i < ROM_BYTES; i++) begin
            sensor.image[i] = 8'(lfsr_bits(8));
        end
        reset_outputs();
        status_polling();
        config_writes();
        burst_readback();
        random_readback();
        address_nack();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors);
        if (total_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end
endmodule

// ==== verilog/cam_sequencer.sv ====
// Sensor bring-up sequencer for register setup, EEPROM dump and status polling
`timescale 1ns/100ps

module cam_sequencer #(
    parameter int ROM_BYTES        = 1664,
    parameter int POLL_WAIT_CYCLES = 24_000_000
) (
    input  logic         clk,
    input  logic         reset,
    i2c_cmd_if.sequencer i2c,
    mem_req_if.client    wr_port,
    output logic         frame_ready,
    output logic         error
);
    import thermal_cam_pkg::*;

    typedef enum logic [2:0] {
        PH_CONTROL,
        PH_CONFIG,
        PH_CLEAR,
        PH_ROM,
        PH_STATUS
    } phase_e;

    typedef enum logic [2:0] {
        S_ISSUE,
        S_WAIT,
        S_STORE,
        S_POLL_WAIT,
        S_READY,
        S_ERROR
    } state_e;

    state_e      state;
    phase_e      phase;
    logic [2:0]  step;
    fb_addr_t    byte_cnt;
    fb_addr_t    rd_total;
    logic [31:0] wait_cnt;
    logic [15:0] reg_addr;
    logic [15:0] reg_data;
    logic        is_rd;
    logic        last;
    byte_t       rx_q;

    assign reg_addr = (phase == PH_CONTROL) ? REG_CONTROL :
                      (phase == PH_CONFIG)  ? REG_CONFIG  :
                      (phase == PH_ROM)     ? EEPROM_BASE : REG_STATUS;
    assign reg_data = (phase == PH_CONTROL) ? CONTROL_VALUE :
                      (phase == PH_CONFIG)  ? CONFIG_VALUE  : STATUS_CLEAR;
    assign is_rd    = (phase == PH_ROM) || (phase == PH_STATUS);
    assign rd_total = (phase == PH_ROM) ? fb_addr_t'(ROM_BYTES) : fb_addr_t'(2);
    assign last     = (byte_cnt == rd_total - 1'b1);

    // Step 0..6 of a write, or pointer set, restart and reads with a final stop
    always_comb begin
        i2c.op    = OP_WRITE;
        i2c.wdata = 8'h00;
        case (step)
            3'd0: i2c.op = OP_START;
            3'd1: i2c.wdata = {CAM_I2C_ADDR, 1'b0};
            3'd2: i2c.wdata = reg_addr[15:8];
            3'd3: i2c.wdata = reg_addr[7:0];
            3'd4: begin
                i2c.op    = is_rd ? OP_START : OP_WRITE;
                i2c.wdata = reg_data[15:8];
            end
            3'd5: i2c.wdata = is_rd ? {CAM_I2C_ADDR, 1'b1} : reg_data[7:0];
            3'd6: begin
                if (!is_rd) i2c.op = OP_STOP;
                else if (last) i2c.op = OP_READ_NACK;
                else i2c.op = OP_READ_ACK;
            end
            default: i2c.op = OP_STOP;
        endcase
    end

    assign i2c.valid     = (state == S_ISSUE);
    assign wr_port.valid = (state == S_STORE);
    assign wr_port.write = 1'b1;
    assign wr_port.addr  = byte_cnt;
    assign wr_port.wdata = rx_q;
    assign frame_ready   = (state == S_READY);
    assign error         = (state == S_ERROR);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_ISSUE;
            phase    <= PH_CONTROL;
            step     <= '0;
            byte_cnt <= '0;
            wait_cnt <= '0;
        end else begin
            case (state)
                S_ISSUE: if (i2c.ready) state <= S_WAIT;
                S_WAIT: begin
                    if (i2c.done && i2c.nack) begin
                        state <= S_ERROR;
                    end else if (i2c.done && is_rd && step == 3'd6) begin
                        rx_q <= i2c.rdata;
                        if (last) step <= 3'd7;
                        if (phase == PH_ROM) begin
                            state <= S_STORE;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= S_ISSUE;
                        end
                    end else if (i2c.done && (step == 3'd7 || step == 3'd6)) begin
                        // Transaction closed by its stop
                        step     <= '0;
                        byte_cnt <= '0;
                        if (phase != PH_STATUS) begin
                            phase <= phase_e'(phase + 3'd1);
                            state <= S_ISSUE;
                        end else if (rx_q[STATUS_READY_BIT]) begin
                            state <= S_READY;
                        end else begin
                            state <= S_POLL_WAIT;
                        end
                    end else if (i2c.done) begin
                        step  <= step + 3'd1;
                        state <= S_ISSUE;
                    end
                end
                S_STORE: begin
                    if (wr_port.ready) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        state    <= S_ISSUE;
                    end
                end
                S_POLL_WAIT: begin
                    wait_cnt <= wait_cnt + 32'd1;
                    if (wait_cnt == 32'(POLL_WAIT_CYCLES - 1)) begin
                        wait_cnt <= '0;
                        state    <= S_ISSUE;
                    end
                end
                default: ;
            endcase
        end
    end
endmodule

// ==== verilog/frame_buffer.sv ====
// Single-port frame buffer with a fixed-priority arbiter for two clients
`timescale 1ns/100ps

module frame_buffer #(
    parameter int FB_DEPTH = 2048
) (
    input  logic       clk,
    input  logic       reset,
    mem_req_if.arbiter wr_port,
    mem_req_if.arbiter rd_port
);
    import thermal_cam_pkg::*;

    localparam int IDX_W = $clog2(FB_DEPTH);

    byte_t    mem [FB_DEPTH];
    byte_t    rdata_q;
    logic     wr_grant;
    logic     rd_grant;
    fb_addr_t addr;
    logic     wen;
    byte_t    wdata;

    // Write port always wins
    assign wr_grant = wr_port.valid;
    assign rd_grant = rd_port.valid && !wr_port.valid;

    assign wr_port.ready = 1'b1;
    assign rd_port.ready = !wr_port.valid;

    assign addr  = wr_grant ? wr_port.addr : rd_port.addr;
    assign wen   = wr_grant ? wr_port.write : (rd_grant && rd_port.write);
    assign wdata = wr_grant ? wr_port.wdata : rd_port.wdata;

    always_ff @(posedge clk) begin
        if (wen) mem[addr[IDX_W-1:0]] <= wdata;
        rdata_q <= mem[addr[IDX_W-1:0]];
    end

    // Both clients see the same read register
    assign wr_port.rdata = rdata_q;
    assign rd_port.rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_port.rvalid <= 1'b0;
            rd_port.rvalid <= 1'b0;
        end else begin
            wr_port.rvalid <= wr_grant && !wr_port.write;
            rd_port.rvalid <= rd_grant && !rd_port.write;
        end
    end
endmodule

// ==== verilog/i2c_cmd_if.sv ====
// I2C command channel between the bring-up sequencer and the bus engine
`timescale 1ns/100ps

interface i2c_cmd_if;
    import thermal_cam_pkg::*;

    // Request side
    logic    valid;
    logic    ready;
    i2c_op_e op;
    byte_t   wdata;

    // Result side, nack and rdata are valid with done
    logic    done;
    logic    nack;
    byte_t   rdata;

    modport master (
        input  valid, op, wdata,
        output ready, done, nack, rdata
    );

    modport sequencer (
        output valid, op, wdata,
        input  ready, done, nack, rdata
    );
endinterface

// ==== verilog/i2c_master.sv ====
// I2C master that runs start, stop, byte write and byte read commands
`timescale 1ns/100ps

module i2c_master #(
    parameter int CLK_DIV = 8
) (
    input  logic      clk,
    input  logic      reset,
    i2c_cmd_if.master cmd,
    output logic      scl,
    output logic      sda_oe,
    input  logic      sda_in
);
    import thermal_cam_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_START, ST_BYTE, ST_STOP} state_e;

    state_e      state;
    logic [15:0] div_cnt;
    logic        tick;
    logic [1:0]  quarter;
    logic [3:0]  bit_cnt;
    byte_t       shreg;
    logic        is_read;
    logic        send_nack;
    logic        held;

    // One tick per quarter SCL period
    assign tick      = (div_cnt == 16'(CLK_DIV - 1));
    assign cmd.ready = (state == ST_IDLE);

    always_ff @(posedge clk) begin
        cmd.done <= 1'b0;
        if (reset) begin
            state    <= ST_IDLE;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
            held     <= 1'b0;
            div_cnt  <= '0;
            quarter  <= '0;
            bit_cnt  <= '0;
            cmd.nack <= 1'b0;
        end else if (state == ST_IDLE) begin
            div_cnt <= '0;
            quarter <= '0;
            bit_cnt <= '0;
            if (cmd.valid) begin
                cmd.nack  <= 1'b0;
                shreg     <= cmd.wdata;
                is_read   <= (cmd.op == OP_READ_ACK) || (cmd.op == OP_READ_NACK);
                send_nack <= (cmd.op == OP_READ_NACK);
                case (cmd.op)
                    OP_START: begin
                        state  <= ST_START;
                        sda_oe <= 1'b0;
                        // Idle bus already has SCL high, skip the rise
                        if (!held) quarter <= 2'd1;
                    end
                    OP_STOP: begin
                        state  <= ST_STOP;
                        sda_oe <= 1'b1;
                    end
                    OP_WRITE: begin
                        state  <= ST_BYTE;
                        sda_oe <= !cmd.wdata[7];
                    end
                    default: begin
                        state  <= ST_BYTE;
                        sda_oe <= 1'b0;
                    end
                endcase
            end
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 16'd1;
            if (tick) begin
                quarter <= quarter + 2'd1;
                case (state)
                    ST_START: begin
                        case (quarter)
                            2'd0: scl <= 1'b1;
                            2'd1: sda_oe <= 1'b1;
                            default: begin
                                scl      <= 1'b0;
                                held     <= 1'b1;
                                state    <= ST_IDLE;
                                cmd.done <= 1'b1;
                            end
                        endcase
                    end
                    ST_STOP: begin
                        if (quarter == 2'd0) begin
                            scl <= 1'b1;
                        end else begin
                            sda_oe   <= 1'b0;
                            held     <= 1'b0;
                            state    <= ST_IDLE;
                            cmd.done <= 1'b1;
                        end
                    end
                    default: begin
                        // Eight data bits then the acknowledge slot
                        case (quarter)
                            2'd0: scl <= 1'b1;
                            2'd1: begin
                                if (bit_cnt == 4'd8) cmd.nack <= !is_read && sda_in;
                                else shreg <= {shreg[6:0], sda_in};
                            end
                            2'd2: scl <= 1'b0;
                            default: begin
                                bit_cnt <= bit_cnt + 4'd1;
                                if (bit_cnt == 4'd8) begin
                                    sda_oe    <= 1'b0;
                                    cmd.rdata <= shreg;
                                    state     <= ST_IDLE;
                                    cmd.done  <= 1'b1;
                                end else if (bit_cnt == 4'd7) begin
                                    sda_oe <= is_read && !send_nack;
                                end else begin
                                    sda_oe <= !is_read && !shreg[7];
                                end
                            end
                        endcase
                    end
                endcase
            end
        end
    end
endmodule

// ==== verilog/mem_req_if.sv ====
// Frame buffer request channel between one client and the arbiter
`timescale 1ns/100ps

interface mem_req_if;
    import thermal_cam_pkg::*;

    logic     valid;
    logic     write;
    fb_addr_t addr;
    byte_t    wdata;
    logic     ready;
    // Read data returns one cycle after the grant
    logic     rvalid;
    byte_t    rdata;

    modport client (
        output valid, write, addr, wdata,
        input  ready, rvalid, rdata
    );

    modport arbiter (
        input  valid, write, addr, wdata,
        output ready, rvalid, rdata
    );
endinterface

// ==== verilog/spi_target.sv ====
// SPI mode-0 target that streams frame buffer bytes to the host
`timescale 1ns/100ps

module spi_target #(
    parameter int FB_DEPTH = 2048
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      sck,
    input  logic      cs,
    input  logic      copi,
    output logic      cipo,
    mem_req_if.client rd_port
);
    import thermal_cam_pkg::*;

    logic [2:0] sck_sync;
    logic [1:0] cs_sync;
    logic [1:0] copi_sync;
    logic       sck_rise;
    logic       sck_fall;
    logic       selected;
    logic [2:0] bit_cnt;
    // 0 and 1 are address bytes, 2 is data
    logic [1:0] byte_cnt;
    logic       fetch;
    fb_addr_t   addr;
    byte_t      next_byte;
    byte_t      tx_sh;

    assign sck_rise = sck_sync[1] && !sck_sync[2];
    assign sck_fall = !sck_sync[1] && sck_sync[2];
    assign selected = !cs_sync[1];
    assign cipo     = tx_sh[7];

    assign rd_port.valid = fetch;
    assign rd_port.write = 1'b0;
    assign rd_port.addr  = addr;
    assign rd_port.wdata = '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            sck_sync  <= '0;
            cs_sync   <= '1;
            copi_sync <= '0;
            bit_cnt   <= '0;
            byte_cnt  <= '0;
            fetch     <= 1'b0;
            tx_sh     <= '0;
        end else begin
            sck_sync  <= {sck_sync[1:0], sck};
            cs_sync   <= {cs_sync[0], cs};
            copi_sync <= {copi_sync[0], copi};
            if (rd_port.valid && rd_port.ready) fetch <= 1'b0;
            if (!selected) begin
                bit_cnt  <= '0;
                byte_cnt <= '0;
                fetch    <= 1'b0;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (byte_cnt != 2'd2) begin
                    addr <= {addr[FB_ADDR_W-2:0], copi_sync[1]};
                end else if (bit_cnt == 3'd7) begin
                    addr <= (addr == fb_addr_t'(FB_DEPTH - 1)) ? '0 : addr + 1'b1;
                end
                // Fetch after the address is in, then one byte ahead
                if (bit_cnt == 3'd7) begin
                    if (byte_cnt != 2'd2) byte_cnt <= byte_cnt + 2'd1;
                    if (byte_cnt != 2'd0) fetch <= 1'b1;
                end
            end else if (sck_fall) begin
                tx_sh <= (bit_cnt == 3'd0) ? next_byte : {tx_sh[6:0], 1'b0};
            end
            if (rd_port.rvalid) next_byte <= rd_port.rdata;
        end
    end
endmodule

// ==== verilog/thermal_cam_pkg.sv ====
// Thermal camera bridge shared types, sensor register map and widths
package thermal_cam_pkg;

    typedef logic [7:0] byte_t;

    localparam int FB_ADDR_W = 14;
    typedef logic [FB_ADDR_W-1:0] fb_addr_t;

    // Bus commands, a start on a held bus becomes a repeated start
    typedef enum logic [2:0] {
        OP_START,
        OP_WRITE,
        OP_READ_ACK,
        OP_READ_NACK,
        OP_STOP
    } i2c_op_e;

    localparam logic [6:0] CAM_I2C_ADDR = 7'h33;

    // Sensor register addresses
    localparam logic [15:0] REG_CONTROL = 16'h800D;
    localparam logic [15:0] REG_CONFIG  = 16'h800F;
    localparam logic [15:0] REG_STATUS  = 16'h8000;
    localparam logic [15:0] EEPROM_BASE = 16'h2400;

    // Values written during bring-up
    localparam logic [15:0] CONTROL_VALUE = 16'h1901;
    localparam logic [15:0] CONFIG_VALUE  = 16'h0000;
    localparam logic [15:0] STATUS_CLEAR  = 16'h0030;

    // Data-ready flag in the status low byte
    localparam int STATUS_READY_BIT = 3;

endpackage

// ==== verilog/thermal_cam_top.sv ====
// Thermal camera bridge from I2C sensor to SPI host through a frame buffer
`timescale 1ns/100ps

module thermal_cam_top #(
    parameter int ROM_BYTES        = 1664,
    parameter int CLK_DIV          = 8,
    parameter int POLL_WAIT_CYCLES = 24_000_000,
    parameter int FB_DEPTH         = 2048
) (
    input  logic clk,
    input  logic reset,
    output logic scl,
    output logic sda_oe,
    input  logic sda_in,
    input  logic sck,
    input  logic cs,
    input  logic copi,
    output logic cipo,
    output logic frame_ready,
    output logic error
);
    i2c_cmd_if i2c_cmd ();
    mem_req_if wr_port ();
    mem_req_if rd_port ();

    i2c_master #(
        .CLK_DIV(CLK_DIV)
    ) i2c_master (
        .clk(clk),
        .reset(reset),
        .cmd(i2c_cmd),
        .scl(scl),
        .sda_oe(sda_oe),
        .sda_in(sda_in)
    );

    cam_sequencer #(
        .ROM_BYTES(ROM_BYTES),
        .POLL_WAIT_CYCLES(POLL_WAIT_CYCLES)
    ) cam_sequencer (
        .clk(clk),
        .reset(reset),
        .i2c(i2c_cmd),
        .wr_port(wr_port),
        .frame_ready(frame_ready),
        .error(error)
    );

    frame_buffer #(
        .FB_DEPTH(FB_DEPTH)
    ) frame_buffer (
        .clk(clk),
        .reset(reset),
        .wr_port(wr_port),
        .rd_port(rd_port)
    );

    spi_target #(
        .FB_DEPTH(FB_DEPTH)
    ) spi_target (
        .clk(clk),
        .reset(reset),
        .sck(sck),
        .cs(cs),
        .copi(copi),
        .cipo(cipo),
        .rd_port(rd_port)
    );
endmodule
